// ==== src/rcn_pkg.sv ====
package rcn_pkg;

    localparam int RCN_ID_W   = 6;
    localparam int RCN_ADDR_W = 22;
    localparam int RCN_DATA_W = 32;

    typedef enum logic
    {
        RCN_READ  = 1'b0,
        RCN_WRITE = 1'b1
    } rcn_op_e;

    typedef enum logic [1:0]
    {
        MST_IDLE = 2'd0,
        MST_SEND = 2'd1,
        MST_WAIT = 2'd2
    } rcn_master_state_e;

    // one ring slot of 69 bits with valid on top
    typedef struct packed
    {
        logic                  valid;
        logic                  req;
        rcn_op_e               op;
        logic [RCN_ID_W-1:0]   id;
        logic [3:0]            mask;
        logic [RCN_ADDR_W-1:0] addr;
        logic [1:0]            seq;
        logic [RCN_DATA_W-1:0] data;
    } rcn_pkt_t;

    // an empty slot
    localparam rcn_pkt_t RCN_IDLE_PKT = '0;

endpackage

// ==== src/rcn_fifo_async.sv ====
`timescale 1ns/100ps

module rcn_fifo_async import rcn_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 2
)
(
    input  logic     main_rst,
    input  logic     wr_clk,
    input  logic     rd_clk,

    input  rcn_pkt_t wr_pkt,
    input  logic     push,
    output logic     full,

    output rcn_pkt_t rd_pkt,
    input  logic     pop,
    output logic     empty
);
    localparam int PTR_W = FIFO_DEPTH_LOG2 + 1;
    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    rcn_pkt_t mem [DEPTH];

    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_next;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_next;
    logic [PTR_W-1:0] rd_gray;

    // gray pointers after crossing into the opposite domain
    logic [PTR_W-1:0] wr_gray_meta;
    logic [PTR_W-1:0] wr_gray_sync;
    logic [PTR_W-1:0] rd_gray_meta;
    logic [PTR_W-1:0] rd_gray_sync;
    logic [PTR_W-1:0] rd_bin_sync;

    function automatic logic [PTR_W-1:0] gray_to_bin(input logic [PTR_W-1:0] gray);
        logic [PTR_W-1:0] bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    assign wr_bin_next = wr_bin + 1'b1;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge wr_clk)
        if (push)
            mem[wr_bin[FIFO_DEPTH_LOG2-1:0]] <= wr_pkt;

    always_ff @(posedge wr_clk or posedge main_rst)
        if (main_rst)
        begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end
        else
        begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
            if (push)
            begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end

    always_ff @(posedge rd_clk or posedge main_rst)
        if (main_rst)
        begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end
        else
        begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
            if (pop)
            begin
                rd_bin  <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end

    // the synchronized read pointer lags, so full may stay up a little long
    assign rd_bin_sync = gray_to_bin(rd_gray_sync);
    assign full = (wr_bin[PTR_W-1] != rd_bin_sync[PTR_W-1]) &&
                  (wr_bin[PTR_W-2:0] == rd_bin_sync[PTR_W-2:0]);

    assign empty  = (rd_gray == wr_gray_sync);
    assign rd_pkt = mem[rd_bin[FIFO_DEPTH_LOG2-1:0]];

endmodule

// ==== src/rcn_bridge_async.sv ====
`timescale 1ns/100ps

module rcn_bridge_async import rcn_pkg::*;
#(
    parameter logic [RCN_ID_W-1:0] ID_MASK         = 6'h30,
    parameter logic [RCN_ID_W-1:0] ID_BASE         = 6'h10,
    parameter logic [23:0]         ADDR_MASK       = 24'hfffc00,
    parameter logic [23:0]         ADDR_BASE       = 24'h000400,
    parameter int                  FIFO_DEPTH_LOG2 = 2
)
(
    input  logic     main_rst,
    input  logic     main_clk,
    input  logic     sub_clk,

    input  rcn_pkt_t main_rcn_in,
    output rcn_pkt_t main_rcn_out,

    input  rcn_pkt_t sub_rcn_in,
    output rcn_pkt_t sub_rcn_out
);
    rcn_pkt_t main_rin;
    rcn_pkt_t sub_rin;

    rcn_pkt_t main_fifo_out;
    logic     main_fifo_push;
    logic     main_fifo_full;
    logic     main_fifo_pop;
    logic     main_fifo_empty;

    rcn_pkt_t sub_fifo_out;
    logic     sub_fifo_push;
    logic     sub_fifo_full;
    logic     sub_fifo_pop;
    logic     sub_fifo_empty;

    logic main_id_match;
    logic main_addr_match;
    logic sub_id_match;
    logic sub_addr_match;

    always_ff @(posedge main_clk or posedge main_rst)
        if (main_rst)
        begin
            main_rin     <= RCN_IDLE_PKT;
            main_rcn_out <= RCN_IDLE_PKT;
        end
        else
        begin
            main_rin <= main_rcn_in;
            if (sub_fifo_pop)
                main_rcn_out <= sub_fifo_out;
            else if (main_fifo_push)
                main_rcn_out <= RCN_IDLE_PKT;
            else
                main_rcn_out <= main_rin;
        end

    always_ff @(posedge sub_clk or posedge main_rst)
        if (main_rst)
        begin
            sub_rin     <= RCN_IDLE_PKT;
            sub_rcn_out <= RCN_IDLE_PKT;
        end
        else
        begin
            sub_rin <= sub_rcn_in;
            if (main_fifo_pop)
                sub_rcn_out <= main_fifo_out;
            else if (sub_fifo_push)
                sub_rcn_out <= RCN_IDLE_PKT;
            else
                sub_rcn_out <= sub_rin;
        end

    assign main_id_match   = (main_rin.id & ID_MASK) == ID_BASE;
    assign main_addr_match = (main_rin.addr & ADDR_MASK[23:2]) == ADDR_BASE[23:2];
    assign sub_id_match    = (sub_rin.id & ID_MASK) == ID_BASE;
    assign sub_addr_match  = (sub_rin.addr & ADDR_MASK[23:2]) == ADDR_BASE[23:2];

    // requests into the window and responses for sub side IDs cross to the sub ring
    assign main_fifo_push = !main_fifo_full && main_rin.valid &&
                            ((main_rin.req && main_addr_match) ||
                             (!main_rin.req && main_id_match));

    // the sub side takes exactly the complement
    assign sub_fifo_push = !sub_fifo_full && sub_rin.valid &&
                           ((sub_rin.req && !sub_addr_match) ||
                            (!sub_rin.req && !sub_id_match));

    // a FIFO head may fill an empty slot or one that is being consumed
    assign main_fifo_pop = !main_fifo_empty && (!sub_rin.valid || sub_fifo_push);
    assign sub_fifo_pop  = !sub_fifo_empty && (!main_rin.valid || main_fifo_push);

    rcn_fifo_async #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) main_fifo
    (
        .main_rst (main_rst),
        .wr_clk   (main_clk),
        .rd_clk   (sub_clk),
        .wr_pkt   (main_rin),
        .push     (main_fifo_push),
        .full     (main_fifo_full),
        .rd_pkt   (main_fifo_out),
        .pop      (main_fifo_pop),
        .empty    (main_fifo_empty)
    );

    rcn_fifo_async #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) sub_fifo
    (
        .main_rst (main_rst),
        .wr_clk   (sub_clk),
        .rd_clk   (main_clk),
        .wr_pkt   (sub_rin),
        .push     (sub_fifo_push),
        .full     (sub_fifo_full),
        .rd_pkt   (sub_fifo_out),
        .pop      (sub_fifo_pop),
        .empty    (sub_fifo_empty)
    );

endmodule

// ==== src/rcn_apb_master.sv ====
`timescale 1ns/100ps

module rcn_apb_master import rcn_pkg::*;
#(
    parameter logic [RCN_ID_W-1:0] MASTER_ID = 6'h01
)
(
    input  logic        main_rst,
    input  logic        main_clk,

    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [23:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,

    input  rcn_pkt_t    ring_in,
    output rcn_pkt_t    ring_out
);
    rcn_master_state_e state;
    rcn_pkt_t          req_pkt;
    logic [1:0]        seq;
    logic              setup;
    logic              own_pkt;

    // a transfer starts only in the setup phase, never in the access cycle that ends one
    assign setup = psel && !penable;

    // either the response to the request or the request itself coming back unclaimed
    assign own_pkt = ring_in.valid && (ring_in.id == MASTER_ID) && (ring_in.seq == seq);

    always_ff @(posedge main_clk)
    begin
        if (state == MST_IDLE && setup)
        begin
            req_pkt.valid <= 1'b1;
            req_pkt.req   <= 1'b1;
            req_pkt.op    <= pwrite ? RCN_WRITE : RCN_READ;
            req_pkt.id    <= MASTER_ID;
            // reads always fetch the whole word
            req_pkt.mask  <= pwrite ? pstrb : 4'hf;
            req_pkt.addr  <= paddr[23:2];
            req_pkt.seq   <= seq;
            req_pkt.data  <= pwdata;
        end
        if (state == MST_WAIT && own_pkt && !ring_in.req)
            prdata <= ring_in.data;
    end

    always_ff @(posedge main_clk or posedge main_rst)
        if (main_rst)
        begin
            state    <= MST_IDLE;
            seq      <= 2'd0;
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            ring_out <= RCN_IDLE_PKT;
        end
        else
        begin
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            ring_out <= ring_in;
            case (state)
                MST_IDLE:
                begin
                    if (setup)
                        state <= MST_SEND;
                end
                MST_SEND:
                begin
                    // wait for an empty slot to carry the request
                    if (!ring_in.valid)
                    begin
                        ring_out <= req_pkt;
                        state    <= MST_WAIT;
                    end
                end
                MST_WAIT:
                begin
                    if (own_pkt)
                    begin
                        ring_out <= RCN_IDLE_PKT;
                        pready   <= 1'b1;
                        pslverr  <= ring_in.req;
                        seq      <= seq + 2'd1;
                        state    <= MST_IDLE;
                    end
                end
                default:
                begin
                    state <= MST_IDLE;
                end
            endcase
        end

endmodule

// ==== src/rcn_ram_slave.sv ====
`timescale 1ns/100ps

module rcn_ram_slave import rcn_pkg::*;
#(
    parameter logic [23:0] ADDR_MASK      = 24'hfffc00,
    parameter logic [23:0] ADDR_BASE      = 24'h000400,
    parameter int          RAM_WORDS_LOG2 = 8
)
(
    input  logic     main_rst,
    input  logic     sub_clk,

    input  rcn_pkt_t ring_in,
    output rcn_pkt_t ring_out
);
    localparam int RAM_WORDS = 1 << RAM_WORDS_LOG2;

    logic [RCN_DATA_W-1:0]     mem [RAM_WORDS];
    logic                      hit;
    logic [RAM_WORDS_LOG2-1:0] idx;
    rcn_pkt_t                  resp;

    assign hit = ring_in.valid && ring_in.req &&
                 ((ring_in.addr & ADDR_MASK[23:2]) == ADDR_BASE[23:2]);
    assign idx = ring_in.addr[RAM_WORDS_LOG2-1:0];

    // the response keeps the slot, id and seq of the request
    always_comb
    begin
        resp     = ring_in;
        resp.req = 1'b0;
        if (ring_in.op == RCN_READ)
            resp.data = mem[idx];
    end

    always_ff @(posedge sub_clk)
        if (hit && ring_in.op == RCN_WRITE)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (ring_in.mask[b])
                    mem[idx][8*b +: 8] <= ring_in.data[8*b +: 8];
            end
        end

    always_ff @(posedge sub_clk or posedge main_rst)
        if (main_rst)
            ring_out <= RCN_IDLE_PKT;
        else if (hit)
            ring_out <= resp;
        else
            ring_out <= ring_in;

endmodule

// ==== src/rcn_subsystem.sv ====
`timescale 1ns/100ps

module rcn_subsystem import rcn_pkg::*;
#(
    parameter logic [RCN_ID_W-1:0] ID_MASK         = 6'h30,
    parameter logic [RCN_ID_W-1:0] ID_BASE         = 6'h10,
    parameter logic [23:0]         ADDR_MASK       = 24'hfffc00,
    parameter logic [23:0]         ADDR_BASE       = 24'h000400,
    parameter logic [RCN_ID_W-1:0] MASTER_ID       = 6'h01,
    parameter int                  RAM_WORDS_LOG2  = 8,
    parameter int                  FIFO_DEPTH_LOG2 = 2
)
(
    input  logic        main_rst,
    input  logic        main_clk,
    input  logic        sub_clk,

    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [23:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr
);
    // main ring on main_clk, sub ring on sub_clk
    rcn_pkt_t main_ring_mst;
    rcn_pkt_t main_ring_brg;
    rcn_pkt_t sub_ring_brg;
    rcn_pkt_t sub_ring_ram;

    rcn_apb_master #(.MASTER_ID(MASTER_ID)) rcn_apb_master_i
    (
        .main_rst (main_rst),
        .main_clk (main_clk),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .pready   (pready),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .ring_in  (main_ring_brg),
        .ring_out (main_ring_mst)
    );

    rcn_bridge_async
    #(
        .ID_MASK         (ID_MASK),
        .ID_BASE         (ID_BASE),
        .ADDR_MASK       (ADDR_MASK),
        .ADDR_BASE       (ADDR_BASE),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    )
    rcn_bridge_async_i
    (
        .main_rst     (main_rst),
        .main_clk     (main_clk),
        .sub_clk      (sub_clk),
        .main_rcn_in  (main_ring_mst),
        .main_rcn_out (main_ring_brg),
        .sub_rcn_in   (sub_ring_ram),
        .sub_rcn_out  (sub_ring_brg)
    );

    rcn_ram_slave
    #(
        .ADDR_MASK      (ADDR_MASK),
        .ADDR_BASE      (ADDR_BASE),
        .RAM_WORDS_LOG2 (RAM_WORDS_LOG2)
    )
    rcn_ram_slave_i
    (
        .main_rst (main_rst),
        .sub_clk  (sub_clk),
        .ring_in  (sub_ring_brg),
        .ring_out (sub_ring_ram)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic main_clk,
    output logic sub_clk,
    output logic main_rst
);
    initial
    begin
        main_clk = 1'b0;
        forever #2 main_clk = ~main_clk;
    end

    initial
    begin
        sub_clk = 1'b0;
        forever #3 sub_clk = ~sub_clk;
    end

    // release on a falling main_clk edge that lies clear of the rising edges of both clocks
    initial
    begin
        main_rst = 1'b1;
        repeat (10) @(posedge main_clk);
        @(negedge main_clk);
        main_rst = 1'b0;
    end

endmodule

// ==== testbench/tb_rcn_subsystem.sv ====
`timescale 1ns/100ps

module tb_rcn_subsystem;

    localparam logic [23:0] ADDR_MASK      = 24'hfffc00;
    localparam logic [23:0] ADDR_BASE      = 24'h000400;
    localparam int          TIMEOUT_CYCLES = 200;

    logic        main_clk;
    logic        sub_clk;
    logic        main_rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [23:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;

    // reference memory indexed by word address bits 7:0
    logic [31:0] model_mem [256];
    logic        model_known [256];

    string       test_name;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        check_read;
    int          xfer_count;
    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    logic        aborted;
    int          seed;

    tb_clock_gen clock_gen_i
    (
        .main_clk (main_clk),
        .sub_clk  (sub_clk),
        .main_rst (main_rst)
    );

    rcn_subsystem
    #(
        .ID_MASK         (6'h30),
        .ID_BASE         (6'h10),
        .ADDR_MASK       (ADDR_MASK),
        .ADDR_BASE       (ADDR_BASE),
        .MASTER_ID       (6'h01),
        .RAM_WORDS_LOG2  (8),
        .FIFO_DEPTH_LOG2 (2)
    )
    rcn_subsystem_i
    (
        .main_rst (main_rst),
        .main_clk (main_clk),
        .sub_clk  (sub_clk),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .pready   (pready),
        .prdata   (prdata),
        .pslverr  (pslverr)
    );

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    function automatic logic in_window(input logic [23:0] addr);
        return (addr & ADDR_MASK) == ADDR_BASE;
    endfunction

    a_idle_after_reset: assert property (@(posedge main_clk) disable iff (main_rst)
        (xfer_count == 0) |-> (!pready && !pslverr))
    else
    begin
        protocol_errors++;
        $display("pready or pslverr went high before any transfer was started");
    end

    a_read_data: assert property (@(posedge main_clk) disable iff (main_rst)
        (pready && check_read) |-> (prdata == exp_rdata))
    else
    begin
        value_errors++;
        $display("FAILED %s: expected %h, actual %h", test_name, exp_rdata, $sampled(prdata));
    end

    a_error_flag: assert property (@(posedge main_clk) disable iff (main_rst)
        pready |-> (pslverr == exp_err))
    else
    begin
        value_errors++;
        $display("FAILED %s: expected %b, actual %b", test_name, exp_err, $sampled(pslverr));
    end

    a_pready_in_access: assert property (@(posedge main_clk) disable iff (main_rst)
        pready |-> (psel && penable))
    else
    begin
        protocol_errors++;
        $display("pready was high outside an access phase in %s", test_name);
    end

    a_pready_one_cycle: assert property (@(posedge main_clk) disable iff (main_rst)
        pready |=> !pready)
    else
    begin
        protocol_errors++;
        $display("pready stayed high for more than one cycle in %s", test_name);
    end

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        @(negedge main_clk);
        while (main_rst !== 1'b0 && cycles < 100)
        begin
            @(negedge main_clk);
            cycles++;
        end
        if (main_rst !== 1'b0)
        begin
            $display("reset was never released");
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic apb_transfer(input string       name,
                                input logic        write,
                                input logic [23:0] addr,
                                input logic [31:0] wdata,
                                input logic [3:0]  strb);
        int         cycles;
        logic [7:0] idx;
        if (!aborted)
        begin
            idx = addr[9:2];
            @(negedge main_clk);
            test_name  = name;
            exp_err    = !in_window(addr);
            check_read = !write && in_window(addr);
            exp_rdata  = model_mem[idx];
            psel       = 1'b1;
            penable    = 1'b0;
            pwrite     = write;
            paddr      = addr;
            pwdata     = wdata;
            pstrb      = strb;
            xfer_count++;
            @(negedge main_clk);
            penable = 1'b1;
            cycles  = 0;
            do
            begin
                @(negedge main_clk);
                cycles++;
            end
            while (!pready && cycles < TIMEOUT_CYCLES);
            if (!pready)
            begin
                $display("no pready within timeout in %s", name);
                timeouts++;
                aborted = 1'b1;
            end
            else
            begin
                if (write && in_window(addr))
                begin
                    model_mem[idx]   = merge_bytes(model_mem[idx], wdata, strb);
                    model_known[idx] = 1'b1;
                end
                // the access phase has to last over the edge that completes it
                @(negedge main_clk);
                psel    = 1'b0;
                penable = 1'b0;
            end
        end
    endtask

    task automatic random_transfers(input int count);
        logic [31:0] rnd;
        logic [7:0]  word;
        logic        write;
        logic [3:0]  strb;
        logic [31:0] data;
        for (int n = 0; n < count; n++)
        begin
            rnd   = $random(seed);
            // sixteen words spread over the window so that reads come often
            word  = {rnd[3:0], 4'h0};
            write = rnd[8];
            strb  = rnd[15:12];
            data  = $random(seed);
            // a word the model has never seen gets a full write first
            if (!model_known[word])
            begin
                write = 1'b1;
                strb  = 4'hf;
            end
            apb_transfer("random", write, ADDR_BASE | {14'd0, word, 2'b00}, data,
                         write ? strb : 4'h0);
        end
    endtask

    initial
    begin
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        pstrb           = '0;
        seed            = 32'h07b0_96a1;
        test_name       = "reset";
        exp_rdata       = '0;
        exp_err         = 1'b0;
        check_read      = 1'b0;
        xfer_count      = 0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        aborted         = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            model_mem[i]   = '0;
            model_known[i] = 1'b0;
        end

        wait_for_reset();
        // pready and pslverr must stay low while the bus idles for a while
        repeat (20) @(negedge main_clk);

        apb_transfer("full_word_write", 1'b1, 24'h000414, 32'h5a3c_96e1, 4'hf);
        apb_transfer("full_word_read", 1'b0, 24'h000414, 32'h0, 4'h0);

        apb_transfer("partial_write_lo", 1'b1, 24'h000414, 32'haabb_ccdd, 4'b0101);
        apb_transfer("partial_read_lo", 1'b0, 24'h000414, 32'h0, 4'h0);
        apb_transfer("partial_write_hi", 1'b1, 24'h000414, 32'h1122_3344, 4'b1000);
        apb_transfer("partial_read_hi", 1'b0, 24'h000414, 32'h0, 4'h0);

        // 0x814 shares its low word bits with 0x414 but lies outside the window
        apb_transfer("outside_read", 1'b0, 24'h000010, 32'h0, 4'h0);
        apb_transfer("outside_write", 1'b1, 24'h000814, 32'hdead_beef, 4'hf);
        apb_transfer("outside_check", 1'b0, 24'h000414, 32'h0, 4'h0);

        random_transfers(50);

        repeat (10) @(negedge main_clk);
        $display("transfers %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 xfer_count, value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
src/rcn_pkg.sv
src/rcn_fifo_async.sv
src/rcn_bridge_async.sv
src/rcn_apb_master.sv
src/rcn_ram_slave.sv
src/rcn_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_rcn_subsystem.sv
